/* compile.f */
design/wtc_pkg.sv
design/wtc_req_stage.sv
design/wtc_write_buffer.sv
design/wtc_write_channel.sv
design/wtc_top.sv
bench/wtc_mem_model.sv
bench/wtc_props.sv
bench/wtc_tb.sv

/* bench/wtc_tb.sv */
/* Directed tests for the cache write path: reset state, latency, lane
   placement, back-pressure and a random stream checked against a byte model. */

`timescale 1ns/1ps
`default_nettype none

module wtc_tb
   import wtc_pkg::*;
();

   localparam int BUF_DEPTH      = 4;
   localparam int TIMEOUT_CYCLES = 2000;   // tests need roughly 500 cycles

   logic    clk_i = 1'b0;
   logic    reset_i;
   logic    fe_valid_i;
   logic    fe_ready_o;
   fe_req_t fe_req_i;
   logic    be_valid_o;
   logic    be_ack_i;
   be_req_t be_req_o;

   be_req_t    exp_q[$];                          // expected back-end writes
   logic [7:0] ref_bytes [logic [ADDR_W-1:0]];
   int         cycles = 0;

   always #20 clk_i = ~clk_i;

   wtc_top #(
      .BUF_DEPTH (BUF_DEPTH)
   ) dut0 (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .fe_valid_i (fe_valid_i),
      .fe_ready_o (fe_ready_o),
      .fe_req_i   (fe_req_i),
      .be_valid_o (be_valid_o),
      .be_ack_i   (be_ack_i),
      .be_req_o   (be_req_o)
   );

   wtc_mem_model mem0 (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .be_valid_i (be_valid_o),
      .be_req_i   (be_req_o),
      .be_ack_o   (be_ack_i)
   );

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
         $display("Testbench failed");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input string test, input logic [BE_DATA_W-1:0] expected,
                              input logic [BE_DATA_W-1:0] actual);
      if (actual !== expected) begin
         $display("Fail %s: expected %0h, actual %0h", test, expected, actual);
         $display("Testbench failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // word address splits into back-end address and lane
   function automatic be_req_t expected_be(input fe_req_t r);
      be_req_t b;
      int      lane;
      lane    = r.addr % LANES;
      b.addr  = r.addr / LANES;
      b.wstrb = '0;
      for (int i = 0; i < FE_NBYTES; i++) begin
         b.wstrb[lane*FE_NBYTES + i] = r.wstrb[i];
      end
      for (int l = 0; l < LANES; l++) begin
         b.wdata[l*FE_DATA_W +: FE_DATA_W] = r.wdata;
      end
      return b;
   endfunction

   // returns on the falling edge after the transfer, valid dropped
   task automatic send_write(input fe_req_t r);
      @(negedge clk_i);
      fe_valid_i = 1'b1;
      fe_req_i   = r;
      #1;
      while (!fe_ready_o) begin
         @(negedge clk_i);
         #1;
      end
      @(posedge clk_i);
      exp_q.push_back(expected_be(r));
      for (int i = 0; i < FE_NBYTES; i++) begin
         if (r.wstrb[i]) begin
            ref_bytes[{r.addr, 2'(i)}] = r.wdata[8*i +: 8];
         end
      end
      @(negedge clk_i);
      fe_valid_i = 1'b0;
   endtask

   task automatic wait_for_log(input int n);
      while (mem0.log_q.size() < n || be_valid_o) begin
         @(negedge clk_i);
      end
   endtask

   task automatic compare_results(input string test);
      check_value({test, " log size"}, exp_q.size(), mem0.log_q.size());
      foreach (exp_q[i]) begin
         check_value({test, " addr"}, exp_q[i].addr, mem0.log_q[i].addr);
         check_value({test, " wstrb"}, exp_q[i].wstrb, mem0.log_q[i].wstrb);
         check_value({test, " wdata"}, exp_q[i].wdata, mem0.log_q[i].wdata);
      end
      check_value({test, " byte count"}, ref_bytes.num(), mem0.bytes.num());
      foreach (ref_bytes[a]) begin
         check_value({test, " byte present"}, 1, mem0.bytes.exists(a));
         check_value({test, " byte"}, ref_bytes[a], mem0.bytes[a]);
      end
      exp_q.delete();
      mem0.log_q.delete();
   endtask

   task automatic reset_state();
      check_value("reset be_valid", 0, be_valid_o);
      check_value("reset fe_ready", 1, fe_ready_o);
   endtask

   task automatic single_write_latency();
      fe_req_t r;
      be_req_t e;
      r = '{addr: 22'h05a2b6, wstrb: 4'hf, wdata: 32'hdeadbeef};
      e = expected_be(r);
      mem0.hold_ack();
      send_write(r);
      check_value("latency edge 1", 0, be_valid_o);
      @(negedge clk_i);
      check_value("latency edge 2", 0, be_valid_o);
      @(negedge clk_i);
      check_value("latency edge 3", 1, be_valid_o);
      check_value("single addr", e.addr, be_req_o.addr);
      check_value("single wstrb", e.wstrb, be_req_o.wstrb);
      check_value("single wdata", e.wdata, be_req_o.wdata);
      mem0.set_fixed(0);
      wait_for_log(1);
      compare_results("single write");
   endtask

   task automatic lane_placement();
      fe_req_t     r;
      logic [15:0] strobes;
      strobes = 16'hb861;   // one partial strobe per lane
      mem0.set_fixed(1);
      for (int l = 0; l < LANES; l++) begin
         r.addr  = {20'h1d2c4, 2'(l)};
         r.wstrb = strobes[4*l +: 4];
         r.wdata = 32'h11223344 * (l + 1);
         send_write(r);
      end
      wait_for_log(LANES);
      compare_results("lane placement");
   endtask

   task automatic back_pressure();
      fe_req_t r;
      int      accepted;
      accepted = 0;
      mem0.hold_ack();
      #1;
      while (fe_ready_o && accepted < 2 * BUF_DEPTH + 2) begin
         r.addr  = 22'h02a000 + accepted;
         r.wstrb = 4'hf;
         r.wdata = 32'hc0de0000 + accepted;
         send_write(r);
         accepted++;
         #1;
      end
      check_value("writes accepted", BUF_DEPTH + 2, accepted);
      repeat (4) begin
         @(negedge clk_i);
         #1;
         check_value("ready held low", 0, fe_ready_o);
      end
      mem0.set_fixed(0);
      wait_for_log(BUF_DEPTH + 2);
      compare_results("back-pressure");
   endtask

   task automatic random_stream();
      fe_req_t r;
      mem0.set_random(3);
      repeat (40) begin
         r.addr  = 22'h100000 | 22'($urandom % 64);   // small window, overlaps happen
         r.wstrb = 4'($urandom);
         r.wdata = $urandom;
         send_write(r);
      end
      wait_for_log(40);
      compare_results("random stream");
   endtask

   initial begin
      void'($urandom(15766));
      reset_i    = 1'b1;
      fe_valid_i = 1'b0;
      fe_req_i   = '0;
      repeat (3) @(negedge clk_i);
      reset_i = 1'b0;
      #1;
      reset_state();
      single_write_latency();
      lane_placement();
      back_pressure();
      random_stream();
      if (dut0.u_props.fail_count == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         $display("Testbench failed");
         $fatal(1, "handshake assertions failed");
      end
   end

endmodule

`default_nettype wire

/* bench/wtc_props.sv */
/* Handshake checks on the front-end and memory ports of the write path,
   bound into every wtc_top instance. */

`timescale 1ns/1ps
`default_nettype none

module wtc_props
   import wtc_pkg::*;
(
   input wire logic    clk_i,
   input wire logic    reset_i,
   input wire logic    fe_valid_i,
   input wire logic    fe_ready_i,
   input wire fe_req_t fe_req_i,
   input wire logic    be_valid_i,
   input wire logic    be_ack_i,
   input wire be_req_t be_req_i
);

   int fail_count = 0;

   // memory request held until acknowledged
   be_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      be_valid_i && !be_ack_i |=> be_valid_i && $stable(be_req_i))
   else begin
      fail_count++;
      $error("back-end request dropped or changed before its acknowledge");
   end

   be_ack_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      be_ack_i |-> be_valid_i)
   else begin
      fail_count++;
      $error("acknowledge without a pending back-end request");
   end

   // front end keeps its offer while stalled
   fe_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      fe_valid_i && !fe_ready_i |=> fe_valid_i && $stable(fe_req_i))
   else begin
      fail_count++;
      $error("front-end request withdrawn or changed while stalled");
   end

endmodule

bind wtc_top wtc_props u_props (
   .clk_i      (clk_i),
   .reset_i    (reset_i),
   .fe_valid_i (fe_valid_i),
   .fe_ready_i (fe_ready_o),
   .fe_req_i   (fe_req_i),
   .be_valid_i (be_valid_o),
   .be_ack_i   (be_ack_i),
   .be_req_i   (be_req_o)
);

`default_nettype wire

/* bench/wtc_mem_model.sv */
/* Back-end memory model for the bench. Acknowledges each write after a fixed,
   random or held-off delay, stores the strobed bytes and logs the request. */

`timescale 1ns/1ps
`default_nettype none

module wtc_mem_model
   import wtc_pkg::*;
(
   input  wire logic    clk_i,
   input  wire logic    reset_i,
   input  wire logic    be_valid_i,
   input  wire be_req_t be_req_i,
   output logic         be_ack_o
);

   int         delay     = 0;
   int         max_delay = 0;
   bit         random_on = 1'b0;
   bit         held      = 1'b0;
   int         wait_cnt  = 0;
   be_req_t    log_q[$];                          // acknowledged writes, in order
   logic [7:0] bytes [logic [ADDR_W-1:0]];

   task automatic set_fixed(input int d);
      delay     = d;
      random_on = 1'b0;
      held      = 1'b0;
   endtask

   task automatic set_random(input int max_d);
      max_delay = max_d;
      delay     = $urandom_range(max_d, 0);
      random_on = 1'b1;
      held      = 1'b0;
   endtask

   task automatic hold_ack();
      held = 1'b1;
   endtask

   initial be_ack_o = 1'b0;

   // ack changes on the falling edge, the DUT sees it at the next rising edge
   always @(negedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         be_ack_o = 1'b0;
         wait_cnt = 0;
      end else if (be_ack_o) begin
         be_ack_o = 1'b0;   // one cycle only
         wait_cnt = 0;
         if (random_on) begin
            delay = $urandom_range(max_delay, 0);
         end
      end else if (be_valid_i && !held) begin
         if (wait_cnt >= delay) begin
            for (int i = 0; i < BE_NBYTES; i++) begin
               if (be_req_i.wstrb[i]) begin
                  bytes[{be_req_i.addr, 4'(i)}] = be_req_i.wdata[8*i +: 8];
               end
            end
            log_q.push_back(be_req_i);
            be_ack_o = 1'b1;
         end else begin
            wait_cnt++;
         end
      end
   end

endmodule

`default_nettype wire

/* design/wtc_top.sv */
/* Write path of the write-through cache: request stage, posted-write buffer
   and memory write channel in a chain. BUF_DEPTH sets the buffer size. */

`timescale 1ns/1ps
`default_nettype none

module wtc_top
   import wtc_pkg::*;
#(
   parameter int BUF_DEPTH = 4
) (
   input  wire logic    clk_i,
   input  wire logic    reset_i,

   // front end
   input  wire logic    fe_valid_i,
   output logic         fe_ready_o,
   input  wire fe_req_t fe_req_i,

   // memory
   output logic         be_valid_o,
   input  wire logic    be_ack_i,
   output be_req_t      be_req_o
);

   logic    req_valid;
   logic    req_ready;
   be_req_t req_data;

   logic    buf_valid;
   logic    buf_ready;
   be_req_t buf_data;

   wtc_req_stage u_req (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_valid_i  (fe_valid_i),
      .in_ready_o  (fe_ready_o),
      .in_req_i    (fe_req_i),
      .out_valid_o (req_valid),
      .out_ready_i (req_ready),
      .out_req_o   (req_data)
   );

   wtc_write_buffer #(
      .BUF_DEPTH (BUF_DEPTH)
   ) u_buf (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .wr_valid_i (req_valid),
      .wr_ready_o (req_ready),
      .wr_req_i   (req_data),
      .rd_valid_o (buf_valid),
      .rd_ready_i (buf_ready),
      .rd_req_o   (buf_data)
   );

   wtc_write_channel u_chan (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_valid_i (buf_valid),
      .req_ready_o (buf_ready),
      .req_i       (buf_data),
      .be_valid_o  (be_valid_o),
      .be_ack_i    (be_ack_i),
      .be_req_o    (be_req_o)
   );

endmodule

`default_nettype wire

/* design/wtc_write_channel.sv */
/* Back-end write FSM. Holds each write on the memory port with be_valid_o high
   until be_ack_i, then goes idle or loads the next write in the same cycle. */

`timescale 1ns/1ps
`default_nettype none

module wtc_write_channel
   import wtc_pkg::*;
(
   input  wire logic    clk_i,
   input  wire logic    reset_i,

   // from the write buffer
   input  wire logic    req_valid_i,
   output logic         req_ready_o,
   input  wire be_req_t req_i,

   // memory port
   output logic         be_valid_o,
   input  wire logic    be_ack_i,
   output be_req_t      be_req_o
);

   typedef enum logic {
      S_IDLE  = 1'b0,
      S_WRITE = 1'b1
   } state_t;

   state_t  state;
   state_t  state_nxt;
   be_req_t req_q;
   logic    load;

   // take a new write when idle or as the current one is acknowledged
   assign req_ready_o = (state == S_IDLE) | be_ack_i;
   assign load        = req_valid_i & req_ready_o;

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: begin
            if (req_valid_i) begin
               state_nxt = S_WRITE;
            end
         end
         S_WRITE: begin
            if (be_ack_i && !req_valid_i) begin
               state_nxt = S_IDLE;
            end
            // ack with a waiting write stays in write, back to back
         end
         default: state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state <= S_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         req_q <= req_i;
      end
   end

   assign be_valid_o = (state == S_WRITE);   // held until the ack
   assign be_req_o   = req_q;

endmodule

`default_nettype wire

/* design/wtc_write_buffer.sv */
/* Posted-write FIFO between the request stage and the memory channel.
   BUF_DEPTH entries, a power of two of at least 2. Push and pop may share a cycle. */

`timescale 1ns/1ps
`default_nettype none

module wtc_write_buffer
   import wtc_pkg::*;
#(
   parameter int BUF_DEPTH = 4
) (
   input  wire logic    clk_i,
   input  wire logic    reset_i,

   // write side
   input  wire logic    wr_valid_i,
   output logic         wr_ready_o,
   input  wire be_req_t wr_req_i,

   // read side
   output logic         rd_valid_o,
   input  wire logic    rd_ready_i,
   output be_req_t      rd_req_o
);

   localparam int PTR_W = $clog2(BUF_DEPTH);

   be_req_t          mem [BUF_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;      // one extra bit to hold BUF_DEPTH
   logic             full;
   logic             wr_fire;
   logic             rd_fire;

   assign full       = (count == (PTR_W + 1)'(BUF_DEPTH));
   assign rd_valid_o = (count != '0);
   assign rd_req_o   = mem[rd_ptr];

   // a pop this cycle frees the place for the push
   assign wr_ready_o = ~full | rd_ready_i;

   assign wr_fire = wr_valid_i & wr_ready_o;
   assign rd_fire = rd_valid_o & rd_ready_i;

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_fire) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
         end
         if (rd_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_fire, rd_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_fire) begin
         mem[wr_ptr] <= wr_req_i;
      end
   end

endmodule

`default_nettype wire

/* design/wtc_req_stage.sv */
/* One-entry input register for front-end writes. Converts each accepted
   word write into a back-end write with replicated data and a lane strobe. */

`timescale 1ns/1ps
`default_nettype none

module wtc_req_stage
   import wtc_pkg::*;
(
   input  wire logic    clk_i,
   input  wire logic    reset_i,

   // front end
   input  wire logic    in_valid_i,
   output logic         in_ready_o,
   input  wire fe_req_t in_req_i,

   // towards the write buffer
   output logic         out_valid_o,
   input  wire logic    out_ready_i,
   output be_req_t      out_req_o
);

   logic              in_fire;
   logic [LANE_W-1:0] lane;

   // free slot, or the held write leaves this cycle
   assign in_ready_o = ~out_valid_o | out_ready_i;
   assign in_fire    = in_valid_i & in_ready_o;

   assign lane = lane_of(in_req_i.addr);

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         out_valid_o <= 1'b0;
      end else if (in_fire) begin
         out_valid_o <= 1'b1;
      end else if (out_ready_i) begin
         out_valid_o <= 1'b0;
      end
   end

   // payload of the accepted write
   always_ff @(posedge clk_i) begin
      if (in_fire) begin
         out_req_o.addr  <= in_req_i.addr[ADDR_W-3:LANE_W];   // drop lane bits
         out_req_o.wstrb <= be_strobe(lane, in_req_i.wstrb);
         out_req_o.wdata <= {LANES{in_req_i.wdata}};          // same word in every lane
      end
   end

endmodule

`default_nettype wire

/* design/wtc_pkg.sv */
/* Shared widths, request structs and lane helpers for the write-through
   cache write path. Imported by every design module and by the bench model. */

`default_nettype none

package wtc_pkg;

   parameter int ADDR_W    = 24;   // byte address
   parameter int FE_DATA_W = 32;
   parameter int BE_DATA_W = 128;
   parameter int FE_NBYTES = FE_DATA_W / 8;
   parameter int BE_NBYTES = BE_DATA_W / 8;
   parameter int LANES     = BE_DATA_W / FE_DATA_W;
   parameter int LANE_W    = 2;    // log2 of LANES

   // front-end word write, word addressed
   typedef struct packed {
      logic [ADDR_W-3:0]    addr;
      logic [FE_NBYTES-1:0] wstrb;
      logic [FE_DATA_W-1:0] wdata;
   } fe_req_t;

   // back-end word write, 16-byte addressed
   typedef struct packed {
      logic [ADDR_W-5:0]    addr;
      logic [BE_NBYTES-1:0] wstrb;
      logic [BE_DATA_W-1:0] wdata;
   } be_req_t;

   // lane of a front-end word inside its back-end word
   function automatic logic [LANE_W-1:0] lane_of(input logic [ADDR_W-3:0] waddr);
      return waddr[LANE_W-1:0];
   endfunction

   // front-end strobe moved up to the addressed lane
   function automatic logic [BE_NBYTES-1:0] be_strobe(
      input logic [LANE_W-1:0]    lane,
      input logic [FE_NBYTES-1:0] strb
   );
      logic [BE_NBYTES-1:0] wide;
      wide = {{(BE_NBYTES - FE_NBYTES){1'b0}}, strb};
      return wide << (lane * FE_NBYTES);
   endfunction

endpackage

`default_nettype wire
